// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "sim passed" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/fetch_buffer.sv ====
`timescale 1ns/100ps

module fetch_buffer import fetch_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  fetch_slot_t [N_WAY-1:0]  hit_slots,
	input  count_t                   hit_count,
	input  logic                     redirect_valid,
	input  addr_t                    redirect_pc,
	input  count_t                   dispatch_count,
	output addr_t                    fetch_pc,
	output count_t                   fetch_count,
	output fetch_slot_t [N_WAY-1:0]  out_slots
);

	// circular instruction queue
	fetch_slot_t  fb_q [N_FB];
	fb_ptr_t      head;           // oldest entry
	fb_ptr_t      tail;           // next free entry
	fb_count_t    occupancy;
	fb_count_t    free_slots;
	fb_count_t    occupancy_next;
	addr_t        pc_step;

	assign free_slots = fb_count_t'(N_FB) - occupancy;

	// never ask for more than fits at the start of the cycle
	assign fetch_count = (free_slots >= fb_count_t'(N_WAY)) ? count_t'(N_WAY)
	                                                       : count_t'(free_slots);

	// dispatch view, oldest first
	always_comb begin
		for (int i = 0; i < N_WAY; i++) begin
			out_slots[i]       = fb_q[head + fb_ptr_t'(i)];
			out_slots[i].valid = fb_count_t'(i) < occupancy;
		end
	end

	assign occupancy_next = occupancy + fb_count_t'(hit_count) - fb_count_t'(dispatch_count);

	// 4 bytes per fetched instruction
	assign pc_step = addr_t'(hit_count) << 2;

	always_ff @(posedge clock) begin
		if (reset) begin
			head      <= '0;
			tail      <= '0;
			occupancy <= '0;
			fetch_pc  <= RESET_PC;
		end else if (redirect_valid) begin
			// drop everything, restart at the target
			head      <= '0;
			tail      <= '0;
			occupancy <= '0;
			fetch_pc  <= redirect_pc;
		end else begin
			head      <= head + fb_ptr_t'(dispatch_count);
			tail      <= tail + fb_ptr_t'(hit_count);
			occupancy <= occupancy_next;
			fetch_pc  <= fetch_pc + pc_step;
		end
	end

	// append this cycle's hits behind the tail
	always_ff @(posedge clock) begin
		if (!redirect_valid) begin
			for (int i = 0; i < N_WAY; i++) begin
				if (count_t'(i) < hit_count)
					fb_q[tail + fb_ptr_t'(i)] <= hit_slots[i];
			end
		end
	end

endmodule

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

	// fetch and dispatch width
	localparam int N_WAY       = 2;
	localparam int N_FB        = 8;    // instruction queue depth
	localparam int CACHE_LINES = 32;
	localparam int FB_PTR_W    = $clog2(N_FB);

	// byte address and instruction word
	typedef logic [31:0] addr_t;
	typedef logic [31:0] inst_t;

	// 0 .. N_WAY instructions
	typedef logic [1:0] count_t;

	// address bits 7:3 pick the line, 31:8 form the tag
	typedef logic [4:0]  line_idx_t;
	typedef logic [23:0] cache_tag_t;

	typedef logic [3:0]  mem_tag_t;    // zero means not accepted
	typedef logic [63:0] block_t;      // two instructions per block

	// queue pointers and occupancy
	typedef logic [FB_PTR_W-1:0] fb_ptr_t;
	typedef logic [FB_PTR_W:0]   fb_count_t;

	localparam addr_t RESET_PC = 32'h0000_0000;

	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_cmd_e;

	// miss handling in the icache
	typedef enum logic {
		IC_IDLE = 1'b0,
		IC_WAIT = 1'b1      // one load outstanding
	} icache_state_e;

	typedef struct packed {
		bus_cmd_e command;
		addr_t    addr;     // bits 2:0 always zero
		block_t   data;
	} mem_req_t;

	// one instruction on its way to dispatch
	typedef struct packed {
		logic  valid;
		addr_t pc;
		inst_t inst;
	} fetch_slot_t;

endpackage

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit import fetch_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     redirect_valid,
	input  addr_t                    redirect_pc,
	input  count_t                   dispatch_count,
	input  mem_req_t                 data_req,
	input  mem_tag_t                 mem_response,
	input  block_t                   mem_data,
	input  mem_tag_t                 mem_tag,
	output mem_req_t                 mem_req,
	output fetch_slot_t [N_WAY-1:0]  out_slots
);

	// buffer to cache
	addr_t                    fetch_pc;
	count_t                   fetch_count;

	// cache back to buffer, same cycle
	fetch_slot_t [N_WAY-1:0]  hit_slots;
	count_t                   hit_count;

	icache u_icache (
		.clock        (clock),
		.reset        (reset),
		.fetch_pc     (fetch_pc),
		.fetch_count  (fetch_count),
		.data_req     (data_req),
		.mem_response (mem_response),
		.mem_data     (mem_data),
		.mem_tag      (mem_tag),
		.mem_req      (mem_req),
		.hit_slots    (hit_slots),
		.hit_count    (hit_count)
	);

	fetch_buffer u_fetch_buffer (
		.clock          (clock),
		.reset          (reset),
		.hit_slots      (hit_slots),
		.hit_count      (hit_count),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.dispatch_count (dispatch_count),
		.fetch_pc       (fetch_pc),
		.fetch_count    (fetch_count),
		.out_slots      (out_slots)
	);

endmodule

// ==== hdl/icache.sv ====
`timescale 1ns/100ps

module icache import fetch_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  addr_t                    fetch_pc,
	input  count_t                   fetch_count,
	input  mem_req_t                 data_req,
	input  mem_tag_t                 mem_response,
	input  block_t                   mem_data,
	input  mem_tag_t                 mem_tag,
	output mem_req_t                 mem_req,
	output fetch_slot_t [N_WAY-1:0]  hit_slots,
	output count_t                   hit_count
);

	// line storage
	block_t                  line_data [CACHE_LINES];
	cache_tag_t              line_tag  [CACHE_LINES];
	logic [CACHE_LINES-1:0]  line_valid;

	icache_state_e           state;
	icache_state_e           state_next;

	// outstanding miss
	mem_tag_t                miss_tag;     // tag handed back by memory
	addr_t                   miss_addr;    // block address being loaded
	line_idx_t               miss_idx;
	cache_tag_t              miss_ctag;

	// lookup side
	line_idx_t               fetch_idx;
	cache_tag_t              fetch_tag;
	addr_t                   fetch_block_addr;
	block_t                  fetch_block;
	logic                    tag_match;
	logic                    lookup_hit;
	count_t                  words_left;

	// memory port control
	logic                    data_busy;
	logic                    issue_load;
	logic                    load_accepted;
	logic                    fill;

	assign fetch_idx        = fetch_pc[7:3];
	assign fetch_tag        = fetch_pc[31:8];
	assign fetch_block_addr = {fetch_pc[31:3], 3'b000};
	assign fetch_block      = line_data[fetch_idx];

	assign miss_idx  = miss_addr[7:3];
	assign miss_ctag = miss_addr[31:8];

	assign tag_match = line_valid[fetch_idx] && (line_tag[fetch_idx] == fetch_tag);

	// the line under a pending fill never hits, other lines still can
	assign lookup_hit = tag_match && !(state == IC_WAIT && fetch_idx == miss_idx);

	// a block holds two words, an odd word start leaves only one
	assign words_left = fetch_pc[2] ? count_t'(1) : count_t'(2);

	always_comb begin
		if (!lookup_hit)
			hit_count = '0;
		else if (fetch_count < words_left)
			hit_count = fetch_count;   // buffer nearly full
		else
			hit_count = words_left;
	end

	// split the block into consecutive slots starting at fetch_pc
	always_comb begin
		addr_t slot_pc;
		for (int i = 0; i < N_WAY; i++) begin
			slot_pc            = fetch_pc + addr_t'(4 * i);
			hit_slots[i].valid = count_t'(i) < hit_count;
			hit_slots[i].pc    = slot_pc;
			hit_slots[i].inst  = slot_pc[2] ? fetch_block[63:32] : fetch_block[31:0];
		end
	end

	assign data_busy = (data_req.command != BUS_NONE);

	// only ask memory when fetch actually wants something, and never in reset
	assign issue_load = !reset && (state == IC_IDLE) && !lookup_hit &&
	                    (fetch_count != '0) && !data_busy;

	assign load_accepted = issue_load && (mem_response != '0);
	assign fill          = (state == IC_WAIT) && (mem_tag == miss_tag);

	// memory port mux
	always_comb begin
		mem_req = '{command: BUS_NONE, addr: '0, data: '0};
		if (data_busy)
			mem_req = data_req;        // data side always wins
		else if (issue_load) begin
			mem_req.command = BUS_LOAD;
			mem_req.addr    = fetch_block_addr;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IC_IDLE: begin
				if (load_accepted)
					state_next = IC_WAIT;
			end
			IC_WAIT: begin
				if (fill)
					state_next = IC_IDLE;
			end
			default: state_next = IC_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= IC_IDLE;
			line_valid <= '0;
		end else begin
			state <= state_next;
			if (fill)
				line_valid[miss_idx] <= 1'b1;
		end
	end

	// miss bookkeeping and line fill
	always_ff @(posedge clock) begin
		if (load_accepted) begin
			miss_tag  <= mem_response;
			miss_addr <= fetch_block_addr;
		end
		if (fill) begin
			line_data[miss_idx] <= mem_data;
			line_tag[miss_idx]  <= miss_ctag;
		end
	end

endmodule

// ==== verif/fetch_unit_tb.sv ====
`timescale 1ns/100ps

module fetch_unit_tb import fetch_pkg::*; ();

	localparam int    SEED_INIT      = 85701;
	localparam int    TIMEOUT_CYCLES = 300;
	localparam int    FIRST_RUN      = 32;     // straight line from reset
	localparam int    REFETCH_RUN    = 24;
	localparam int    RANDOM_RUN     = 600;
	localparam inst_t IMAGE_KEY      = 32'h5A3C_96E1;

	logic                     clock;
	logic                     reset;
	logic                     redirect_valid;
	addr_t                    redirect_pc;
	count_t                   dispatch_count;
	mem_req_t                 data_req;
	mem_req_t                 mem_req;
	mem_tag_t                 mem_response;
	mem_tag_t                 mem_tag;
	block_t                   mem_data;
	block_t                   image_block;
	fetch_slot_t [N_WAY-1:0]  out_slots;

	integer  seed;
	int      n_dispatched;     // instructions checked so far
	addr_t   expect_pc;        // pc the next dispatched slot must carry
	logic    flushed;          // reset or redirect at the last edge
	logic    watch_refetch;
	addr_t   refetch_limit;    // blocks below this are already cached
	logic    redirects_on;
	int      stall_left;

	// program image
	function automatic inst_t ref_inst(input addr_t pc);
		return pc ^ IMAGE_KEY;
	endfunction

	// valid slots counted from slot 0
	function automatic count_t count_valid(input fetch_slot_t [N_WAY-1:0] slots);
		count_t n;
		n = '0;
		for (int i = 0; i < N_WAY; i++) begin
			if (slots[i].valid && n == count_t'(i))
				n = n + count_t'(1);
		end
		return n;
	endfunction

	always #50 clock = ~clock;

	fetch_unit u_dut (
		.clock          (clock),
		.reset          (reset),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.dispatch_count (dispatch_count),
		.data_req       (data_req),
		.mem_response   (mem_response),
		.mem_data       (mem_data),
		.mem_tag        (mem_tag),
		.mem_req        (mem_req),
		.out_slots      (out_slots)
	);

	// low word is the even instruction of the block
	assign image_block = {ref_inst(mem_req.addr + 32'd4), ref_inst(mem_req.addr)};

	mem_model #(.SEED(SEED_INIT)) u_mem (
		.clock        (clock),
		.reset        (reset),
		.mem_req      (mem_req),
		.image_block  (image_block),
		.mem_response (mem_response),
		.mem_data     (mem_data),
		.mem_tag      (mem_tag)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_port();
		if (data_req.command != BUS_NONE) begin
			assert (mem_req == data_req)
			else stop_run($sformatf("FAIL mem_req got %h expected %h", mem_req, data_req));
		end
		if (mem_req.command != BUS_NONE) begin
			assert (mem_req.addr[2:0] == 3'b000)
			else stop_run($sformatf("FAIL mem_req.addr[2:0] got %h expected %h",
				mem_req.addr[2:0], 3'b000));
		end
		// refetch pass must be served from the cache
		if (watch_refetch && data_req.command == BUS_NONE && mem_req.command == BUS_LOAD) begin
			assert (mem_req.addr >= refetch_limit)
			else stop_run($sformatf("instruction load issued for cached block at %h",
				mem_req.addr));
		end
	endtask

	task automatic check_dispatch();
		for (int i = 0; i < N_WAY; i++) begin
			if (count_t'(i) < dispatch_count) begin
				assert (out_slots[i].pc == expect_pc)
				else stop_run($sformatf("FAIL out_slots[%0d].pc got %h expected %h",
					i, out_slots[i].pc, expect_pc));
				assert (out_slots[i].inst == ref_inst(expect_pc))
				else stop_run($sformatf("FAIL out_slots[%0d].inst got %h expected %h",
					i, out_slots[i].inst, ref_inst(expect_pc)));
				expect_pc    = expect_pc + 32'd4;
				n_dispatched = n_dispatched + 1;
			end
		end
	endtask

	// compare at each edge, inputs are stable here
	always @(posedge clock) begin
		if (reset) begin
			assert (mem_req.command == BUS_NONE)
			else stop_run($sformatf("FAIL mem_req.command got %h expected %h",
				mem_req.command, BUS_NONE));
			expect_pc    = RESET_PC;
			n_dispatched = 0;
			flushed      = 1'b1;
		end else begin
			// queue comes back empty after a flush
			if (flushed) begin
				for (int i = 0; i < N_WAY; i++) begin
					assert (!out_slots[i].valid)
					else stop_run($sformatf("FAIL out_slots[%0d].valid got %h expected %h",
						i, out_slots[i].valid, 1'b0));
				end
			end
			check_port();
			check_dispatch();
			flushed = redirect_valid;
			if (redirect_valid)
				expect_pc = redirect_pc;
		end
	end

	task automatic drive_cycle();
		count_t avail;
		@(posedge clock);
		#10;
		avail          = count_valid(out_slots);
		redirect_valid = 1'b0;
		data_req       = '{command: BUS_NONE, addr: '0, data: '0};
		if (($unsigned($random(seed)) % 4) == 0) begin
			data_req.command = ($random(seed) & 1) ? BUS_LOAD : BUS_STORE;
			data_req.addr    = addr_t'($random(seed)) & 32'hFFFF_FFF8;
			data_req.data    = {$random(seed), $random(seed)};
		end
		if (redirects_on && ($unsigned($random(seed)) % 24) == 0) begin
			redirect_valid = 1'b1;
			redirect_pc    = addr_t'($random(seed)) & 32'h0000_0FFC;   // 4 KB, lines collide
		end
		if (redirect_valid)
			dispatch_count = '0;
		else if (stall_left > 0) begin
			stall_left     = stall_left - 1;
			dispatch_count = '0;
		end else if (($unsigned($random(seed)) % 16) == 0) begin
			stall_left     = 1 + int'($unsigned($random(seed)) % 12);
			dispatch_count = '0;
		end else
			dispatch_count = count_t'($unsigned($random(seed)) % (32'(avail) + 32'd1));
	endtask

	task automatic apply_redirect(input addr_t target);
		@(posedge clock);
		#10;
		redirect_valid = 1'b1;
		redirect_pc    = target;
		dispatch_count = '0;
		data_req       = '{command: BUS_NONE, addr: '0, data: '0};
	endtask

	// run until target instructions are checked, fail if dispatch stalls too long
	task automatic run_until(input int target);
		int idle;
		int last;
		idle = 0;
		last = n_dispatched;
		while (n_dispatched < target) begin
			drive_cycle();
			if (n_dispatched != last) begin
				last = n_dispatched;
				idle = 0;
			end else
				idle = idle + 1;
			if (idle >= TIMEOUT_CYCLES)
				stop_run("timeout: no instruction was dispatched for 300 cycles");
		end
	endtask

	initial begin
		seed           = SEED_INIT;
		clock          = 1'b0;
		reset          = 1'b1;
		redirect_valid = 1'b0;
		redirect_pc    = RESET_PC;
		dispatch_count = '0;
		data_req       = '{command: BUS_NONE, addr: '0, data: '0};
		watch_refetch  = 1'b0;
		refetch_limit  = '0;
		redirects_on   = 1'b0;
		stall_left     = 0;
		repeat (4) @(posedge clock);
		#10;
		reset = 1'b0;

		run_until(FIRST_RUN);

		// jump back to the start, the blocks dispatched so far stay cached
		refetch_limit = addr_t'(4 * n_dispatched) & 32'hFFFF_FFF8;
		watch_refetch = 1'b1;
		apply_redirect(RESET_PC);
		run_until(n_dispatched + REFETCH_RUN);
		watch_refetch = 1'b0;

		redirects_on = 1'b1;
		run_until(n_dispatched + RANDOM_RUN);

		$display("sim passed");
		$finish;
	end

endmodule

// ==== verif/mem_model.sv ====
`timescale 1ns/100ps

module mem_model import fetch_pkg::*; #(
	parameter int SEED = 85701
) (
	input  logic     clock,
	input  logic     reset,
	input  mem_req_t mem_req,
	input  block_t   image_block,    // program data for mem_req.addr
	output mem_tag_t mem_response,
	output block_t   mem_data,
	output mem_tag_t mem_tag
);

	typedef struct packed {
		mem_tag_t    tag;
		block_t      data;
		logic [31:0] due;             // cycle the data comes back
	} pending_t;

	pending_t     pending [$];
	pending_t     entry;
	integer       seed;
	logic         accept_now;       // drawn once per cycle
	mem_tag_t     next_tag;
	logic [31:0]  cycle;
	logic         took_any;
	logic         took_load;
	mem_tag_t     took_tag;
	block_t       took_data;
	logic         found;
	int           pick;

	assign mem_response = (mem_req.command != BUS_NONE && accept_now) ? next_tag : '0;

	initial begin
		seed       = SEED;
		accept_now = 1'b0;
		next_tag   = 4'd1;
		cycle      = '0;
		mem_tag    = '0;
		mem_data   = '0;
	end

	always begin
		@(posedge clock);
		// what the port did in the cycle that just ended
		took_any  = (mem_response != '0);
		took_load = took_any && (mem_req.command == BUS_LOAD);
		took_tag  = mem_response;
		took_data = image_block;
		#10;
		cycle = cycle + 32'd1;
		if (reset) begin
			pending.delete();
			next_tag   = 4'd1;
			mem_tag    = '0;
			accept_now = 1'b0;
		end else begin
			if (took_load) begin
				entry.tag  = took_tag;
				entry.data = took_data;
				entry.due  = cycle + 32'd1 + ($unsigned($random(seed)) % 8);   // 2 to 9 cycles
				pending.push_back(entry);
			end
			if (took_any)
				next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;   // stores use a tag too

			// one return per cycle, late ones wait
			mem_tag  = '0;
			mem_data = '0;
			found    = 1'b0;
			pick     = 0;
			for (int i = 0; i < pending.size(); i++) begin
				if (!found && pending[i].due <= cycle) begin
					mem_tag  = pending[i].tag;
					mem_data = pending[i].data;
					pick     = i;
					found    = 1'b1;
				end
			end
			if (found)
				pending.delete(pick);

			accept_now = ($unsigned($random(seed)) % 4) != 0;   // three in four accepted
		end
	end

endmodule

// ==== vlog.f ====
hdl/fetch_pkg.sv
hdl/icache.sv
hdl/fetch_buffer.sv
hdl/fetch_unit.sv
verif/mem_model.sv
verif/fetch_unit_tb.sv
